// ==== compile.f ====
+incdir+.
uart_pkg.sv
uart_apb_regs.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
uart_assertions.sv
uart_tb.sv

// ==== Bender.yml ====
package:
  name: uart_apb

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - uart_pkg.sv
      - uart_apb_regs.sv
      - uart_tx.sv
      - uart_rx.sv
      - uart_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - uart_assertions.sv
      - uart_tb.sv

// ==== uart_tb.sv ====
`include "uart_cfg.svh"

module uart_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import uart_pkg::*;

	localparam int W             = `UART_DATA_WIDTH;
	localparam int CLK_PERIOD    = 8;
	localparam int BIT_T         = `UART_CLKS_PER_BIT * CLK_PERIOD; // ns per serial bit
	localparam int LOOP_FRAMES   = 20;
	localparam int FORMAT_FRAMES = 4;
	localparam int ERR_FRAMES    = 6;
	localparam int NUM_FRAMES    = LOOP_FRAMES + FORMAT_FRAMES + 1 + ERR_FRAMES; // one busy frame
	localparam int TIMEOUT_NS    = NUM_FRAMES * 11 * BIT_T + 40000;

	logic        clk;
	logic        reset;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        serial_out;
	logic        serial_in;
	logic        loop_sel; // 1 feeds rx from tx, 0 from the injector
	logic        inj_line;
	logic [31:0] rng;
	int          errors;
	int          checks;
	int          tests;
	int          err_mark;

	uart_top u_uart_top (
		.clk, .reset,
		.i_psel(psel), .i_penable(penable), .i_pwrite(pwrite), .i_paddr(paddr),
		.i_pwdata(pwdata), .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
		.o_serial_out(serial_out), .i_serial_in(serial_in)
	);

	assign serial_in = loop_sel ? serial_out : inj_line;

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired before all tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// parity bit that makes the count of ones even, or odd when odd is set
	function automatic logic model_parity(input logic [W-1:0] d, input logic odd);
		int ones;
		ones = 0;
		for (int i = 0; i < W; i++) ones += d[i];
		return odd ? (ones % 2 == 0) : (ones % 2 == 1);
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		@(posedge clk);
		#1;
		psel    = 1'b1; // setup phase
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#1 penable = 1'b1;
		#5;
		rdata = prdata; // sampled well inside the access cycle
		err   = pslverr;
		check("o_pready", pready, 1'b1);
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic reg_write(input logic [3:0] addr, input logic [31:0] data, input logic exp_err);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b1, addr, data, rd, err);
		check("o_pslverr", err, exp_err);
	endtask

	task automatic reg_read(input logic [3:0] addr, output logic [31:0] rdata);
		logic err;
		apb_xfer(1'b0, addr, 32'h0, rdata, err);
		check("o_pslverr", err, 1'b0);
	endtask

	task automatic wait_status(input int idx, input logic val, output logic [31:0] rdata);
		int polls;
		polls = 0;
		rdata = 32'h0;
		do begin
			reg_read(REG_STATUS, rdata);
			polls++;
		end while (rdata[idx] !== val && polls < 600);
		if (rdata[idx] !== val) begin
			errors++;
			$display("STATUS bit %0d never became %0d", idx, val);
		end
	endtask

	// follows o_serial_out from its start edge and samples each bit near mid-bit
	task automatic capture_frame(input logic [W-1:0] exp, input logic pen, input logic podd);
		@(negedge serial_out);
		#(BIT_T / 2 + 2);
		check("o_serial_out start", serial_out, 1'b0);
		for (int i = 0; i < W; i++) begin
			#(BIT_T);
			check("o_serial_out data", serial_out, exp[i]);
		end
		if (pen) begin
			#(BIT_T);
			check("o_serial_out parity", serial_out, model_parity(exp, podd));
		end
		#(BIT_T);
		check("o_serial_out stop", serial_out, 1'b1);
	endtask

	task automatic drive_bit(input logic b);
		@(posedge clk);
		#1 inj_line = b;
		repeat (`UART_CLKS_PER_BIT - 1) @(posedge clk);
	endtask

	task automatic inject_frame(input logic [W-1:0] d, input logic pen, input logic podd,
			input logic bad_par, input logic bad_stop);
		drive_bit(1'b0);
		for (int i = 0; i < W; i++) drive_bit(d[i]);
		if (pen) drive_bit(model_parity(d, podd) ^ bad_par);
		drive_bit(~bad_stop);
		drive_bit(1'b1); // idle gap
		drive_bit(1'b1);
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %s done with %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	initial begin
		logic [31:0] rd;
		logic [W-1:0] b;
		logic pen;
		logic podd;
		int kind;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = 4'h0;
		pwdata   = 32'h0;
		loop_sel = 1'b1;
		inj_line = 1'b1;
		rng      = 32'hd299_cdb3;
		errors   = 0;
		checks   = 0;
		tests    = 0;
		err_mark = 0;
		reset    = 1'b1;
		repeat (8) @(posedge clk);
		#1 reset = 1'b0;

		reg_read(REG_STATUS, rd);
		check("STATUS", rd, 32'h0);
		reg_read(REG_CTRL, rd);
		check("CTRL", rd, 32'h0);
		check("o_serial_out", serial_out, 1'b1);
		end_test("reset state");

		for (int i = 0; i < LOOP_FRAMES; i++) begin
			rng  = xorshift(rng);
			b    = rng[W-1:0];
			pen  = rng[16];
			podd = rng[17];
			reg_write(REG_CTRL, {30'h0, podd, pen}, 1'b0);
			reg_write(REG_DATA, 32'(b), 1'b0);
			wait_status(1, 1'b1, rd);
			check("STATUS error", rd[2], 1'b0);
			reg_read(REG_DATA, rd);
			check("DATA", rd, 32'(b));
			reg_read(REG_STATUS, rd);
			check("STATUS valid", rd[1], 1'b0);
			wait_status(0, 1'b0, rd);
		end
		end_test("loopback");

		for (int i = 0; i < FORMAT_FRAMES; i++) begin
			rng  = xorshift(rng);
			b    = rng[W-1:0];
			pen  = rng[16];
			podd = rng[17];
			reg_write(REG_CTRL, {30'h0, podd, pen}, 1'b0);
			fork
				reg_write(REG_DATA, 32'(b), 1'b0);
				capture_frame(b, pen, podd);
			join
			wait_status(0, 1'b0, rd);
			reg_read(REG_DATA, rd);
			check("DATA", rd, 32'(b));
		end
		end_test("frame format");

		rng = xorshift(rng);
		b   = rng[W-1:0];
		reg_write(REG_CTRL, 32'h0, 1'b0);
		fork
			begin
				reg_write(REG_DATA, 32'(b), 1'b0);
				repeat (12) @(posedge clk);
				reg_write(REG_DATA, 32'(~b), 1'b1); // line is busy
			end
			capture_frame(b, 1'b0, 1'b0);
		join
		reg_write(REG_STATUS, 32'h7, 1'b1);
		reg_write(4'hc, 32'h1, 1'b1);
		wait_status(0, 1'b0, rd);
		reg_read(REG_DATA, rd);
		check("DATA", rd, 32'(b));
		end_test("busy rejection");

		loop_sel = 1'b0;
		for (int i = 0; i < ERR_FRAMES; i++) begin
			rng  = xorshift(rng);
			b    = rng[W-1:0];
			kind = i % 3; // good, bad parity, low stop
			pen  = (kind == 1) ? 1'b1 : rng[16];
			podd = rng[17];
			reg_write(REG_CTRL, {30'h0, podd, pen}, 1'b0);
			inject_frame(b, pen, podd, kind == 1, kind == 2);
			wait_status(1, 1'b1, rd);
			check("STATUS error", rd[2], kind != 0);
			reg_read(REG_DATA, rd);
			check("DATA", rd, 32'(b));
		end
		end_test("error detection");

		errors += u_uart_top.u_assertions.fails;
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== uart_assertions.sv ====
module uart_assertions (
	input logic clk,
	input logic reset,
	input logic i_psel,
	input logic i_penable,
	input logic i_pready,
	input logic i_pslverr,
	input logic i_serial_out,
	input logic i_tx_busy,
	input logic i_rx_done
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned fails = 0; // read by the testbench at the end
	logic        access;

	assign access = i_psel & i_penable;

	apb_ready_known: assert property (@(posedge clk) disable iff (reset)
		access |-> (i_pready === 1'b1) && !$isunknown(i_pslverr))
		else begin fails++; $error("pready low or pslverr unknown in access phase"); end

	apb_err_in_access: assert property (@(posedge clk) disable iff (reset)
		!access |-> !i_pslverr)
		else begin fails++; $error("pslverr outside access phase"); end

	line_idle_high: assert property (@(posedge clk) disable iff (reset)
		!i_tx_busy |-> i_serial_out)
		else begin fails++; $error("serial line low while tx idle"); end

	rx_done_pulse: assert property (@(posedge clk) disable iff (reset)
		i_rx_done |=> !i_rx_done)
		else begin fails++; $error("rx_done longer than one cycle"); end

endmodule

bind uart_top uart_assertions u_assertions (
	.clk, .reset, .i_psel, .i_penable,
	.i_pready(o_pready), .i_pslverr(o_pslverr), .i_serial_out(o_serial_out),
	.i_tx_busy(tx_busy), .i_rx_done(rx_done)
);

// ==== uart_top.sv ====
`include "uart_cfg.svh"

module uart_top (
	input  logic        clk,
	input  logic        reset,
	input  logic        i_psel,
	input  logic        i_penable,
	input  logic        i_pwrite,
	input  logic [3:0]  i_paddr,
	input  logic [31:0] i_pwdata,
	output logic [31:0] o_prdata,
	output logic        o_pready,
	output logic        o_pslverr,
	output logic        o_serial_out,
	input  logic        i_serial_in
);

	logic                        tx_start;
	logic [`UART_DATA_WIDTH-1:0] tx_data;
	logic                        tx_busy;
	logic                        parity_en;
	logic                        parity_odd;
	logic [`UART_DATA_WIDTH-1:0] rx_data;
	logic                        rx_parity_err;
	logic                        rx_done;

	uart_apb_regs u_regs (
		.clk, .reset,
		.i_psel, .i_penable, .i_pwrite, .i_paddr, .i_pwdata,
		.o_prdata, .o_pready, .o_pslverr,
		.i_tx_busy(tx_busy), .i_rx_done(rx_done), .i_rx_data(rx_data),
		.i_rx_parity_err(rx_parity_err),
		.o_tx_start(tx_start), .o_tx_data(tx_data),
		.o_parity_en(parity_en), .o_parity_odd(parity_odd)
	);

	uart_tx u_tx (
		.clk, .reset, .i_start(tx_start), .i_data(tx_data),
		.i_parity_en(parity_en), .i_parity_odd(parity_odd),
		.o_serial_out, .o_busy(tx_busy)
	);

	uart_rx u_rx (
		.clk, .reset, .i_serial_in, .i_parity_en(parity_en), .i_parity_odd(parity_odd),
		.o_data(rx_data), .o_parity_err(rx_parity_err), .o_done(rx_done)
	);

endmodule

// ==== uart_rx.sv ====
`include "uart_cfg.svh"

module uart_rx (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_serial_in,
	input  logic                        i_parity_en,
	input  logic                        i_parity_odd,
	output logic [`UART_DATA_WIDTH-1:0] o_data,
	output logic                        o_parity_err,
	output logic                        o_done
);
	import uart_pkg::*;

	localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT + 1);
	localparam int IDX_W = $clog2(`UART_DATA_WIDTH);
	localparam int HALF  = (`UART_CLKS_PER_BIT / 2 > 0) ? `UART_CLKS_PER_BIT / 2 : 1;

	uart_rx_state_e              state;
	logic [`UART_SYNC_STAGES-1:0] sync_q;
	logic                        line;
	logic                        line_q;
	logic [CNT_W-1:0]            bit_cnt;
	logic [IDX_W-1:0]            bit_idx;
	logic                        sample;
	logic [`UART_DATA_WIDTH-1:0] data_q;
	logic                        parity_acc;
	logic                        parity_en_q;
	logic                        parity_odd_q;

	assign line = sync_q[`UART_SYNC_STAGES-1];

	// mid-bit strobe, half a bit into the start bit then a full bit each time
	assign sample = (state == RX_START) ? (bit_cnt == CNT_W'(HALF - 1)) :
		(bit_cnt == CNT_W'(`UART_CLKS_PER_BIT - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q       <= '1; // line idles high
			line_q       <= 1'b1;
			state        <= RX_IDLE;
			bit_cnt      <= '0;
			bit_idx      <= '0;
			o_done       <= 1'b0;
			o_parity_err <= 1'b0;
		end else begin
			sync_q <= {sync_q[`UART_SYNC_STAGES-2:0], i_serial_in};
			line_q <= line;
			o_done <= 1'b0;
			if (state == RX_IDLE || sample) begin
				bit_cnt <= '0;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
			case (state)
				RX_IDLE: if (line_q && !line) state <= RX_START; // falling edge
				RX_START: begin
					if (sample) begin
						state   <= line ? RX_IDLE : RX_DATA; // glitch goes back to idle
						bit_idx <= '0;
					end
				end
				RX_DATA: begin
					if (sample) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == IDX_W'(`UART_DATA_WIDTH - 1)) begin
							state <= parity_en_q ? RX_PARITY : RX_STOP;
						end
					end
				end
				RX_PARITY: if (sample) state <= RX_STOP;
				RX_STOP: begin
					if (sample) begin
						state        <= RX_IDLE;
						o_done       <= 1'b1;
						o_parity_err <= (parity_en_q & (parity_acc ^ parity_odd_q)) | ~line;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// shift register and running parity
	always_ff @(posedge clk) begin
		if (state == RX_IDLE) begin
			parity_acc   <= 1'b0;
			parity_en_q  <= i_parity_en;
			parity_odd_q <= i_parity_odd;
		end else if (sample && (state == RX_DATA || state == RX_PARITY)) begin
			parity_acc <= parity_acc ^ line;
			if (state == RX_DATA) begin
				data_q <= {line, data_q[`UART_DATA_WIDTH-1:1]}; // LSB arrives first
			end
		end
	end

	assign o_data = data_q; // stable from stop bit until next frame

endmodule

// ==== uart_tx.sv ====
`include "uart_cfg.svh"

module uart_tx (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_start,
	input  logic [`UART_DATA_WIDTH-1:0] i_data,
	input  logic                        i_parity_en,
	input  logic                        i_parity_odd,
	output logic                        o_serial_out,
	output logic                        o_busy
);
	import uart_pkg::*;

	localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT + 1);
	localparam int IDX_W = $clog2(`UART_DATA_WIDTH);

	uart_tx_state_e              state;
	logic [CNT_W-1:0]            bit_cnt;
	logic [IDX_W-1:0]            bit_idx;
	logic [`UART_DATA_WIDTH-1:0] shift_q;
	logic                        parity_en_q;
	logic                        parity_bit_q;
	logic                        bit_end;

	assign bit_end = (bit_cnt == CNT_W'(`UART_CLKS_PER_BIT - 1)); // last clk of a bit

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= TX_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
		end else begin
			if (state == TX_IDLE || bit_end) begin
				bit_cnt <= '0;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
			case (state)
				TX_IDLE: if (i_start) state <= TX_START;
				TX_START: begin
					if (bit_end) begin
						state   <= TX_DATA;
						bit_idx <= '0;
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == IDX_W'(`UART_DATA_WIDTH - 1)) begin
							state <= parity_en_q ? TX_PARITY : TX_STOP;
						end
					end
				end
				TX_PARITY: if (bit_end) state <= TX_STOP;
				TX_STOP:   if (bit_end) state <= TX_IDLE;
				default:   state <= TX_IDLE;
			endcase
		end
	end

	// frame payload, captured at start and shifted LSB first
	always_ff @(posedge clk) begin
		if (state == TX_IDLE && i_start) begin
			shift_q      <= i_data;
			parity_en_q  <= i_parity_en;
			parity_bit_q <= (^i_data) ^ i_parity_odd; // even sense unless odd set
		end else if (state == TX_DATA && bit_end) begin
			shift_q <= shift_q >> 1;
		end
	end

	always_comb begin
		case (state)
			TX_START:  o_serial_out = 1'b0;
			TX_DATA:   o_serial_out = shift_q[0];
			TX_PARITY: o_serial_out = parity_bit_q;
			default:   o_serial_out = 1'b1; // idle and stop are mark
		endcase
	end

	assign o_busy = (state != TX_IDLE);

endmodule

// ==== uart_apb_regs.sv ====
`include "uart_cfg.svh"

module uart_apb_regs (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_psel,
	input  logic                        i_penable,
	input  logic                        i_pwrite,
	input  logic [3:0]                  i_paddr,
	input  logic [31:0]                 i_pwdata,
	output logic [31:0]                 o_prdata,
	output logic                        o_pready,
	output logic                        o_pslverr,
	input  logic                        i_tx_busy,
	input  logic                        i_rx_done,
	input  logic [`UART_DATA_WIDTH-1:0] i_rx_data,
	input  logic                        i_rx_parity_err,
	output logic                        o_tx_start,
	output logic [`UART_DATA_WIDTH-1:0] o_tx_data,
	output logic                        o_parity_en,
	output logic                        o_parity_odd
);
	import uart_pkg::*;

	uart_reg_e                   reg_sel;
	logic                        access;
	logic                        bad_access;
	logic                        wr_ok;
	logic                        data_rd;
	logic [31:0]                 rd_data;
	logic                        parity_en_q;
	logic                        parity_odd_q;
	logic                        rx_valid_q;
	logic                        rx_err_q;
	logic [`UART_DATA_WIDTH-1:0] rx_data_q;

	assign reg_sel = uart_reg_e'(i_paddr);
	assign access  = i_psel & i_penable; // APB access phase

	// read mux and error decode per offset
	always_comb begin
		rd_data    = 32'h0;
		bad_access = 1'b0;
		case (reg_sel)
			REG_DATA: begin
				rd_data    = 32'(rx_data_q);
				bad_access = i_pwrite & i_tx_busy; // no write while a frame is on the line
			end
			REG_STATUS: begin
				rd_data    = {29'h0, rx_err_q, rx_valid_q, i_tx_busy};
				bad_access = i_pwrite; // read only
			end
			REG_CTRL: begin
				rd_data = {30'h0, parity_odd_q, parity_en_q};
			end
			default: begin
				bad_access = 1'b1; // unmapped offset
			end
		endcase
	end

	assign wr_ok   = access & i_pwrite & ~bad_access;
	assign data_rd = access & ~i_pwrite & (reg_sel == REG_DATA);

	assign o_prdata  = rd_data;
	assign o_pready  = 1'b1; // zero wait states
	assign o_pslverr = access & bad_access;

	assign o_tx_start   = wr_ok & (reg_sel == REG_DATA);
	assign o_tx_data    = i_pwdata[`UART_DATA_WIDTH-1:0]; // engine latches on start
	assign o_parity_en  = parity_en_q;
	assign o_parity_odd = parity_odd_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			parity_en_q  <= 1'b0;
			parity_odd_q <= 1'b0;
		end else if (wr_ok && reg_sel == REG_CTRL) begin
			parity_en_q  <= i_pwdata[0];
			parity_odd_q <= i_pwdata[1];
		end
	end

	// receive holding state, a new byte overwrites an unread one
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_valid_q <= 1'b0;
			rx_err_q   <= 1'b0;
		end else if (i_rx_done) begin
			rx_valid_q <= 1'b1; // done beats a same-cycle read clear
			rx_err_q   <= i_rx_parity_err;
		end else if (data_rd) begin
			rx_valid_q <= 1'b0;
			rx_err_q   <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (i_rx_done) begin
			rx_data_q <= i_rx_data;
		end
	end

endmodule

// ==== uart_pkg.sv ====
package uart_pkg;

	// APB word offsets
	typedef enum logic [3:0] {
		REG_DATA   = 4'h0, // wr starts tx, rd returns rx byte
		REG_STATUS = 4'h4, // tx busy, rx valid, rx error
		REG_CTRL   = 4'h8  // parity enable, odd parity
	} uart_reg_e;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} uart_tx_state_e;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} uart_rx_state_e;

endpackage

// ==== uart_cfg.svh ====
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// build-time sizing of the UART

`define UART_DATA_WIDTH   8 // data bits per frame

`define UART_CLKS_PER_BIT 8 // clk cycles per serial bit

`define UART_SYNC_STAGES  3 // flops on the rx line input

`endif
